/* include/exu_tb_vectors.svh */
////////////////////////////////////////////////////////////////////////////
// Execute stage test table
// One add_row call per directed test
////////////////////////////////////////////////////////////////////////////

`ifndef EXU_TB_VECTORS_SVH
`define EXU_TB_VECTORS_SVH

// Arguments in order are name, op, rs1, rs2, second operand, rd, jump imm target,
// stall, then address, read en, lanes, store data, jump, target, result and write en
task automatic load_vectors();
    add_row("add", ADD, 'h5, 'h0, 'h7, 5'd1, 'h200, 1'b0,
            'hc, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'hc, 1'b1);
    add_row("sub", SUB, 'h5, 'h0, 'h7, 5'd2, 'h200, 1'b0,
            'hc, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'hffff_fffe, 1'b1);
    add_row("and", AND, 'hf0f0, 'h0, 'hff00, 5'd3, 'h200, 1'b0,
            'h1_eff0, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'hf000, 1'b1);
    add_row("or", OR, 'hf0f0, 'h0, 'hff00, 5'd3, 'h200, 1'b0,
            'h1_eff0, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'hfff0, 1'b1);
    add_row("xor", XOR, 'hf0f0, 'h0, 'hff00, 5'd3, 'h200, 1'b0,
            'h1_eff0, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h0ff0, 1'b1);
    add_row("sll", SLL, 'h1, 'h0, 'h4, 5'd4, 'h200, 1'b0,
            'h4, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h10, 1'b1);
    add_row("srl", SRL, 'h8000_0000, 'h0, 'h4, 5'd4, 'h200, 1'b0,
            'h8000_0004, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h0800_0000, 1'b1);
    add_row("sra", SRA, 'h8000_0000, 'h0, 'h4, 5'd4, 'h200, 1'b0,
            'h8000_0004, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'hf800_0000, 1'b1);
    add_row("slt", SLT, 'hffff_ffff, 'h0, 'h1, 5'd5, 'h200, 1'b0,
            'h0, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h1, 1'b1);
    add_row("sltu", SLTU, 'hffff_ffff, 'h0, 'h1, 5'd5, 'h200, 1'b0,
            'h0, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h0, 1'b1);
    add_row("lui", LUI, 'h0, 'h0, 'h1234_5000, 5'd6, 'h200, 1'b0,
            'h1234_5000, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h1234_5000, 1'b1);
    add_row("auipc", AUIPC, 'h0, 'h0, 'h1000, 5'd6, 'h1100, 1'b0,
            'h1000, 1'b0, 4'h0, 'h0, 1'b0, 'h1100, 'h1100, 1'b1);
    add_row("jal", JAL, 'h0, 'h0, 'h0, 5'd1, 'h300, 1'b0,
            'h0, 1'b0, 4'h0, 'h0, 1'b1, 'h300, 'h104, 1'b1);
    add_row("jalr", JALR, 'h401, 'h0, 'h10, 5'd1, 'h300, 1'b0,
            'h410, 1'b0, 4'h0, 'h0, 1'b1, 'h410, 'h104, 1'b1);
    add_row("add_rd0", ADD, 'h1, 'h0, 'h1, 5'd0, 'h200, 1'b0,
            'h0, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h2, 1'b0);
    add_row("beq_eq", BEQ, 'h9, 'h0, 'h9, 5'd5, 'h200, 1'b0,
            'h10, 1'b0, 4'h0, 'h0, 1'b1, 'h200, 'h12, 1'b0);
    add_row("beq_ne", BEQ, 'h9, 'h0, 'h8, 5'd5, 'h200, 1'b0,
            'h10, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h11, 1'b0);
    add_row("bne_eq", BNE, 'h9, 'h0, 'h9, 5'd5, 'h200, 1'b0,
            'h10, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h12, 1'b0);
    add_row("bne_ne", BNE, 'h9, 'h0, 'h8, 5'd5, 'h200, 1'b0,
            'h10, 1'b0, 4'h0, 'h0, 1'b1, 'h200, 'h11, 1'b0);
    add_row("blt_less", BLT, 'hffff_fffe, 'h0, 'h1, 5'd5, 'h200, 1'b0,
            'hffff_fffc, 1'b0, 4'h0, 'h0, 1'b1, 'h200, 'hffff_ffff, 1'b0);
    add_row("blt_greater", BLT, 'h3, 'h0, 'h2, 5'd5, 'h200, 1'b0,
            'h4, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h5, 1'b0);
    add_row("bltu_greater", BLTU, 'hffff_fffe, 'h0, 'h1, 5'd5, 'h200, 1'b0,
            'hffff_fffc, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'hffff_ffff, 1'b0);
    add_row("bltu_less", BLTU, 'h1, 'h0, 'hffff_fffe, 5'd5, 'h200, 1'b0,
            'hffff_fffc, 1'b0, 4'h0, 'h0, 1'b1, 'h200, 'hffff_ffff, 1'b0);
    add_row("bge_greater", BGE, 'h3, 'h0, 'h2, 5'd5, 'h200, 1'b0,
            'h4, 1'b0, 4'h0, 'h0, 1'b1, 'h200, 'h5, 1'b0);
    add_row("bge_equal", BGE, 'h7, 'h0, 'h7, 5'd5, 'h200, 1'b0,
            'hc, 1'b0, 4'h0, 'h0, 1'b1, 'h200, 'he, 1'b0);
    add_row("bge_less", BGE, 'hffff_fffe, 'h0, 'h1, 5'd5, 'h200, 1'b0,
            'hffff_fffc, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'hffff_ffff, 1'b0);
    add_row("bgeu_greater", BGEU, 'hffff_fffe, 'h0, 'h1, 5'd5, 'h200, 1'b0,
            'hffff_fffc, 1'b0, 4'h0, 'h0, 1'b1, 'h200, 'hffff_ffff, 1'b0);
    add_row("bgeu_less", BGEU, 'h1, 'h0, 'hffff_fffe, 5'd5, 'h200, 1'b0,
            'hffff_fffc, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'hffff_ffff, 1'b0);
    add_row("lw", LW, 'h1000, 'h0, 'h6, 5'd7, 'h200, 1'b0,
            'h1004, 1'b1, 4'h0, 'h0, 1'b0, 'h200, 'h1006, 1'b1);
    add_row("lbu", LBU, 'h1000, 'h0, 'h6, 5'd7, 'h200, 1'b0,
            'h1004, 1'b1, 4'h0, 'h0, 1'b0, 'h200, 'h1006, 1'b1);
    add_row("lh", LH, 'h3000, 'h0, 'h2, 5'd8, 'h200, 1'b0,
            'h3000, 1'b1, 4'h0, 'h0, 1'b0, 'h200, 'h3002, 1'b1);
    add_row("sb", SB, 'h2000, 'hab, 'h3, 5'd0, 'h200, 1'b0,
            'h2000, 1'b0, 4'h8, 'habab_abab, 1'b0, 'h200, 'h2003, 1'b0);
    add_row("sb_lane1", SB, 'h2000, 'h5a, 'h1, 5'd0, 'h200, 1'b0,
            'h2000, 1'b0, 4'h2, 'h5a5a_5a5a, 1'b0, 'h200, 'h2001, 1'b0);
    add_row("sh", SH, 'h2000, 'h1234_cdef, 'h2, 5'd0, 'h200, 1'b0,
            'h2000, 1'b0, 4'hc, 'hcdef_cdef, 1'b0, 'h200, 'h2002, 1'b0);
    add_row("sh_low", SH, 'h2000, 'hdead_beef, 'h0, 5'd0, 'h200, 1'b0,
            'h2000, 1'b0, 4'h3, 'hbeef_beef, 1'b0, 'h200, 'h2000, 1'b0);
    add_row("sw", SW, 'h2000, 'h1234_cdef, 'h0, 5'd0, 'h200, 1'b0,
            'h2000, 1'b0, 4'hf, 'h1234_cdef, 1'b0, 'h200, 'h2000, 1'b0);
    add_row("add_stall", ADD, 'h64, 'h0, 'h1, 5'd9, 'h200, 1'b1,
            'h64, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h65, 1'b1);
    add_row("nop", NOP, 'h0, 'h0, 'h0, 5'd4, 'h200, 1'b0,
            'h0, 1'b0, 4'h0, 'h0, 1'b0, 'h200, 'h0, 1'b0);
endtask

`endif

/* bench/exu_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Execute stage testbench
// Directed table and random ALU pass
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exu_tb;

    import exu_pkg::*;

    localparam int PERIOD      = 100;
    localparam int NUM_ROWS    = 38;
    localparam int NUM_RANDOM  = 20;
    localparam int SEED        = 32'h0c92_1ef3;

    typedef struct packed {
        exu_issue_t           issue;
        logic                 stall;
        exu_mem_req_t         mem;
        exu_jump_t            jump;
        logic [31:0]          result;
        logic                 we;
    } vector_t;

    logic         clk;
    logic         reset_n;
    logic         stall;
    exu_issue_t   issue;
    exu_mem_req_t mem_req;
    exu_jump_t    jump;
    exu_wb_t      wb_fwd;
    exu_wb_t      wb;

    vector_t      vectors [NUM_ROWS];
    string        names [NUM_ROWS];
    int           row_count   = 0;
    int           error_count = 0;
    int           test_errors = 0;
    int           test_count  = 0;
    integer       seed        = SEED;

    exu_top i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .stall_i   (stall),
        .issue_i   (issue),
        .mem_req_o (mem_req),
        .jump_o    (jump),
        .wb_fwd_o  (wb_fwd),
        .wb_o      (wb)
    );

    task automatic add_row(input string name, input exu_op_e op, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [31:0] opb, input logic [4:0] rd,
                           input logic [31:0] jt, input logic stl, input logic [31:0] addr,
                           input logic re, input logic [3:0] lanes, input logic [31:0] wdata,
                           input logic jmp, input logic [31:0] target,
                           input logic [31:0] result, input logic we);
        vector_t v;
        v.issue = '{op: op, rs1_data: rs1, rs2_data: rs2, second_operand: opb, rd: rd,
                    pc_next: 32'h104, jump_imm_target: jt};
        v.stall = stl;
        v.mem   = '{address: addr, read_enable: re, write_enable: lanes, write_data: wdata};
        v.jump  = '{jump: jmp, target: target};
        v.result = result;
        v.we     = we;
        vectors[row_count] = v;
        names[row_count]   = name;
        row_count++;
    endtask

    `include "exu_tb_vectors.svh"

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %h actual %h", test, field, exp, act);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string test);
        if (test_errors == 0) begin
            $display("test %s: ok", test);
        end else begin
            $display("test %s: %0d mismatches", test, test_errors);
        end
        test_count++;
        test_errors = 0;
    endtask

    // Reference model for the random ALU pass
    function automatic logic [31:0] model_alu(input exu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            SUB:     return a + ~b + 32'd1;
            XOR:     return a ^ b;
            SLTU:    return {31'd0, (a < b)};
            SRA:     return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            default: return a + b;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Directed table
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_table();
        logic [31:0] prev_result;
        logic [4:0]  prev_rd;
        logic        prev_we;
        exu_op_e     prev_op;

        prev_result = '0;
        prev_rd     = '0;
        prev_we     = 1'b0;
        prev_op     = NOP;

        for (int i = 0; i < row_count; i++) begin
            @(negedge clk);
            issue = vectors[i].issue;
            stall = vectors[i].stall;
            #(PERIOD/2 - 10);    // Just before the rising edge
            check_value(names[i], "address", vectors[i].mem.address, mem_req.address);
            check_value(names[i], "read_en", {31'd0, vectors[i].mem.read_enable},
                        {31'd0, mem_req.read_enable});
            check_value(names[i], "lanes", {28'd0, vectors[i].mem.write_enable},
                        {28'd0, mem_req.write_enable});
            check_value(names[i], "wdata", vectors[i].mem.write_data, mem_req.write_data);
            check_value(names[i], "jump", {31'd0, vectors[i].jump.jump}, {31'd0, jump.jump});
            check_value(names[i], "target", vectors[i].jump.target, jump.target);
            check_value(names[i], "fwd_result", vectors[i].result, wb_fwd.result);
            check_value(names[i], "fwd_we", {31'd0, vectors[i].we},
                        {31'd0, wb_fwd.write_enable});
            check_value(names[i], "fwd_rd", {27'd0, vectors[i].issue.rd},
                        {27'd0, wb_fwd.rd});
            check_value(names[i], "fwd_op", {27'd0, vectors[i].issue.op},
                        {27'd0, wb_fwd.op});
            @(posedge clk);
            #1;
            if (!vectors[i].stall) begin
                prev_result = vectors[i].result;
                prev_rd     = vectors[i].issue.rd;
                prev_we     = vectors[i].we;
                prev_op     = vectors[i].issue.op;
            end
            check_value(names[i], "wb_result", prev_result, wb.result);
            check_value(names[i], "wb_rd", {27'd0, prev_rd}, {27'd0, wb.rd});
            check_value(names[i], "wb_we", {31'd0, prev_we}, {31'd0, wb.write_enable});
            check_value(names[i], "wb_op", {27'd0, prev_op}, {27'd0, wb.op});
            finish_test(names[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Random ALU pass
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_random_alu();
        exu_op_e     rop;
        logic [31:0] exp;
        string       tname;

        for (int i = 0; i < NUM_RANDOM; i++) begin
            case (i % 5)
                0:       rop = ADD;
                1:       rop = SUB;
                2:       rop = XOR;
                3:       rop = SLTU;
                default: rop = SRA;
            endcase
            @(negedge clk);
            stall = 1'b0;
            issue = '0;
            issue.op             = rop;
            issue.rs1_data       = $random(seed);
            issue.second_operand = $random(seed);
            issue.rd             = 5'd10;
            exp   = model_alu(rop, issue.rs1_data, issue.second_operand);
            tname = $sformatf("random_%0d_%s", i, rop.name());
            #(PERIOD/2 - 10);
            check_value(tname, "fwd_result", exp, wb_fwd.result);
            @(posedge clk);
            #1;
            check_value(tname, "wb_result", exp, wb.result);
            finish_test(tname);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

    // Watchdog
    initial begin
        #(PERIOD * 1000);
        $display("Simulation ran too long without finishing");
        $display("Verification failed");
        $finish;
    end

    initial begin
        int wait_cnt;

        stall = 1'b1;    // Register frozen until the first row
        issue = '0;
        load_vectors();

        wait_cnt = 0;
        while (!reset_n && wait_cnt < 20) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!reset_n) begin
            $display("Reset was never released");
            $display("Verification failed");
            $finish;
        end else begin
            check_value("reset", "wb_we", 32'd0, {31'd0, wb.write_enable});
            check_value("reset", "wb_op", {27'd0, NOP}, {27'd0, wb.op});
            check_value("reset", "wb_result", 32'd0, wb.result);
            check_value("reset", "wb_rd", 32'd0, {27'd0, wb.rd});
            finish_test("reset");

            apply_table();
            run_random_alu();

            $display("%0d tests run, %0d errors", test_count, error_count);
            if (error_count == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* exu_top.f */
+incdir+include
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_branch.sv
verilog/exu_lsu.sv
verilog/exu_stage_reg.sv
verilog/exu_top.sv
bench/exu_tb.sv

/* include/exu_consts.svh */
////////////////////////////////////////////////////////////////////////////
// Execute stage constants
// Word, register address, shift amount and byte lane widths
////////////////////////////////////////////////////////////////////////////

`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// Data path word
`define EXU_XLEN        32

// Register file address
`define EXU_REG_ADDR_W  5

`define EXU_SHAMT_W     5   // Low bits of the second operand

// Byte lanes in one word
`define EXU_BYTE_EN_W   4

`endif

/* run_sim.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f exu_top.f --top-module exu_tb -o exu_sim || exit 1

out=$(./obj_dir/exu_sim)
echo "$out"

echo "$out" | grep -q "Verification passed" && exit 0 || exit 1

/* verilog/exu_alu.sv */
////////////////////////////////////////////////////////////////////////////
// Execute ALU
// Arithmetic, logic, shifts, compares and stage result selection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_alu (
    input  var exu_pkg::exu_issue_t issue_i,
    output logic [`EXU_XLEN-1:0]    sum_o,
    output exu_pkg::exu_cmp_t       cmp_o,
    output logic [`EXU_XLEN-1:0]    result_o
);

    import exu_pkg::*;

    logic [`EXU_XLEN-1:0]    op_a;
    logic [`EXU_XLEN-1:0]    op_b;
    logic [`EXU_SHAMT_W-1:0] shamt;

    logic [`EXU_XLEN-1:0]    diff;
    logic [`EXU_XLEN-1:0]    and_res;
    logic [`EXU_XLEN-1:0]    or_res;
    logic [`EXU_XLEN-1:0]    xor_res;
    logic [`EXU_XLEN-1:0]    sll_res;
    logic [`EXU_XLEN-1:0]    srl_res;
    logic [`EXU_XLEN-1:0]    sra_res;

    assign op_a  = issue_i.rs1_data;
    assign op_b  = issue_i.second_operand;
    assign shamt = op_b[`EXU_SHAMT_W-1:0];

    //////////////////////////////////////////////////////////////////////////
    // Operators
    //////////////////////////////////////////////////////////////////////////

    // Sum also feeds address and JALR target
    assign sum_o   = op_a + op_b;
    assign diff    = op_a - op_b;
    assign and_res = op_a & op_b;
    assign or_res  = op_a | op_b;
    assign xor_res = op_a ^ op_b;

    assign sll_res = op_a << shamt;
    assign srl_res = op_a >> shamt;
    assign sra_res = $signed(op_a) >>> shamt;

    assign cmp_o.equal = (op_a == op_b);
    assign cmp_o.lt    = ($signed(op_a) < $signed(op_b));
    assign cmp_o.ltu   = (op_a < op_b);

    //////////////////////////////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (issue_i.op)
            SUB:       result_o = diff;
            AND:       result_o = and_res;
            OR:        result_o = or_res;
            XOR:       result_o = xor_res;
            SLL:       result_o = sll_res;
            SRL:       result_o = srl_res;
            SRA:       result_o = sra_res;
            SLT:       result_o = {{(`EXU_XLEN-1){1'b0}}, cmp_o.lt};
            SLTU:      result_o = {{(`EXU_XLEN-1){1'b0}}, cmp_o.ltu};
            LUI:       result_o = op_b;                     // Immediate already shifted
            AUIPC:     result_o = issue_i.jump_imm_target;  // PC plus immediate
            JAL, JALR: result_o = issue_i.pc_next;          // Link value
            default:   result_o = sum_o;                    // ADD, loads, stores
        endcase
    end

endmodule

`default_nettype wire

/* verilog/exu_branch.sv */
////////////////////////////////////////////////////////////////////////////
// Branch unit
// Jump decision from the compare flags and jump target selection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_branch (
    input  var exu_pkg::exu_op_e     op_i,
    input  var exu_pkg::exu_cmp_t    cmp_i,
    input  logic [`EXU_XLEN-1:0]     sum_i,
    input  logic [`EXU_XLEN-1:0]     jump_imm_target_i,
    output exu_pkg::exu_jump_t       jump_o
);

    import exu_pkg::*;

    logic take;

    // Branch condition per operation
    always_comb begin
        unique case (op_i)
            BEQ:       take = cmp_i.equal;
            BNE:       take = !cmp_i.equal;
            BLT:       take = cmp_i.lt;
            BLTU:      take = cmp_i.ltu;
            BGE:       take = !cmp_i.lt;
            BGEU:      take = !cmp_i.ltu;
            JAL, JALR: take = 1'b1;     // Unconditional
            default:   take = 1'b0;
        endcase
    end

    assign jump_o.jump = take;

    // JALR target is register based with bit 0 forced low
    always_comb begin
        if (op_i == JALR) begin
            jump_o.target = {sum_i[`EXU_XLEN-1:1], 1'b0};
        end else begin
            jump_o.target = jump_imm_target_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/exu_lsu.sv */
////////////////////////////////////////////////////////////////////////////
// Load/store request unit
// Aligned address, read enable, lane enables and store data
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_lsu (
    input  var exu_pkg::exu_op_e     op_i,
    input  logic [`EXU_XLEN-1:0]     sum_i,
    input  logic [`EXU_XLEN-1:0]     rs2_data_i,
    output exu_pkg::exu_mem_req_t    mem_req_o
);

    import exu_pkg::*;

    logic [1:0]                byte_sel;
    logic [`EXU_BYTE_EN_W-1:0] lane_en;
    logic [`EXU_XLEN-1:0]      store_data;

    assign byte_sel = sum_i[1:0];

    // Word address, lanes pick the bytes
    assign mem_req_o.address     = {sum_i[`EXU_XLEN-1:2], 2'b00};
    assign mem_req_o.read_enable = (op_i inside {LB, LBU, LH, LHU, LW});

    //////////////////////////////////////////////////////////////////////////
    // Store lanes
    //////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            SB: begin
                unique case (byte_sel)
                    2'b00:   lane_en = 4'b0001;
                    2'b01:   lane_en = 4'b0010;
                    2'b10:   lane_en = 4'b0100;
                    default: lane_en = 4'b1000;
                endcase
            end
            SH:      lane_en = byte_sel[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
            SW:      lane_en = 4'b1111;
            default: lane_en = 4'b0000;
        endcase
    end

    // Replicate so any enabled lane sees the right byte
    always_comb begin
        unique case (op_i)
            SB:      store_data = {4{rs2_data_i[7:0]}};
            SH:      store_data = {2{rs2_data_i[15:0]}};
            default: store_data = rs2_data_i;
        endcase
    end

    assign mem_req_o.write_enable = lane_en;
    assign mem_req_o.write_data   = store_data;

endmodule

`default_nettype wire

/* verilog/exu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Execute stage types
// Operation encoding and the records passed between the units
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "exu_consts.svh"

package exu_pkg;

    // Decoded operation, 5 bits
    typedef enum logic [4:0] {
        NOP,
        ADD, SUB,
        AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW
    } exu_op_e;

    // Instruction as handed over by decode
    typedef struct packed {
        exu_op_e                    op;
        logic [`EXU_XLEN-1:0]       rs1_data;
        logic [`EXU_XLEN-1:0]       rs2_data;
        logic [`EXU_XLEN-1:0]       second_operand;  // Register or immediate
        logic [`EXU_REG_ADDR_W-1:0] rd;
        logic [`EXU_XLEN-1:0]       pc_next;
        logic [`EXU_XLEN-1:0]       jump_imm_target;
    } exu_issue_t;

    // Comparison flags of rs1 against the second operand
    typedef struct packed {
        logic equal;
        logic lt;   // Signed
        logic ltu;  // Unsigned
    } exu_cmp_t;

    typedef struct packed {
        logic [`EXU_XLEN-1:0]      address;
        logic                      read_enable;
        logic [`EXU_BYTE_EN_W-1:0] write_enable;  // One bit per lane
        logic [`EXU_XLEN-1:0]      write_data;
    } exu_mem_req_t;

    typedef struct packed {
        logic                 jump;
        logic [`EXU_XLEN-1:0] target;
    } exu_jump_t;

    // Writeback payload
    typedef struct packed {
        logic                       write_enable;
        exu_op_e                    op;
        logic [`EXU_XLEN-1:0]       result;
        logic [`EXU_REG_ADDR_W-1:0] rd;
    } exu_wb_t;

endpackage

`default_nettype wire

/* verilog/exu_stage_reg.sv */
////////////////////////////////////////////////////////////////////////////
// Writeback stage register
// Write enable rule, forward path and the stall-held output register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_stage_reg (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        stall_i,
    input  var exu_pkg::exu_op_e        op_i,
    input  logic [`EXU_REG_ADDR_W-1:0]  rd_i,
    input  logic [`EXU_XLEN-1:0]        result_i,
    output exu_pkg::exu_wb_t            wb_fwd_o,
    output exu_pkg::exu_wb_t            wb_o
);

    import exu_pkg::*;

    logic write_enable;

    // No register write for stores and conditional branches
    always_comb begin
        unique case (op_i)
            NOP,
            SB, SH, SW,
            BEQ, BNE,
            BLT, BLTU,
            BGE, BGEU: write_enable = 1'b0;
            default:   write_enable = (rd_i != '0);  // x0 is never written
        endcase
    end

    // Forward path for the next instruction's operands
    assign wb_fwd_o.write_enable = write_enable;
    assign wb_fwd_o.op           = op_i;
    assign wb_fwd_o.result       = result_i;
    assign wb_fwd_o.rd           = rd_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_o <= '{write_enable: 1'b0, op: NOP, result: '0, rd: '0};
        end else if (!stall_i) begin
            wb_o <= wb_fwd_o;  // Hold while stalled
        end
    end

endmodule

`default_nettype wire

/* verilog/exu_top.sv */
////////////////////////////////////////////////////////////////////////////
// Integer execute stage
// ALU, branch unit, load/store request and writeback register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    stall_i,
    input  var exu_pkg::exu_issue_t issue_i,

    // Data memory request
    output exu_pkg::exu_mem_req_t   mem_req_o,

    // Fetch redirect
    output exu_pkg::exu_jump_t      jump_o,

    // Register file write, unregistered and registered
    output exu_pkg::exu_wb_t        wb_fwd_o,
    output exu_pkg::exu_wb_t        wb_o
);

    import exu_pkg::*;

    logic [`EXU_XLEN-1:0] sum;     // rs1 plus second operand
    exu_cmp_t             cmp;
    logic [`EXU_XLEN-1:0] result;

    //////////////////////////////////////////////////////////////////////////
    // Producers
    //////////////////////////////////////////////////////////////////////////

    exu_alu u_alu (
        .issue_i  (issue_i),
        .sum_o    (sum),
        .cmp_o    (cmp),
        .result_o (result)
    );

    // Branch decision uses ALU flags
    exu_branch u_branch (
        .op_i              (issue_i.op),
        .cmp_i             (cmp),
        .sum_i             (sum),
        .jump_imm_target_i (issue_i.jump_imm_target),
        .jump_o            (jump_o)
    );

    exu_lsu u_lsu (
        .op_i       (issue_i.op),
        .sum_i      (sum),
        .rs2_data_i (issue_i.rs2_data),
        .mem_req_o  (mem_req_o)
    );

    //////////////////////////////////////////////////////////////////////////
    // Writeback register
    //////////////////////////////////////////////////////////////////////////

    exu_stage_reg u_stage_reg (
        .clk      (clk),
        .reset_n  (reset_n),
        .stall_i  (stall_i),
        .op_i     (issue_i.op),
        .rd_i     (issue_i.rd),
        .result_i (result),
        .wb_fwd_o (wb_fwd_o),
        .wb_o     (wb_o)
    );

endmodule

`default_nettype wire
